// ==== vlsu_cfg_pkg.sv ====
// Vector LSU sizes and widths

package vlsu_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  // One 32-bit lane shared by memory and VRF
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned DATA_BYTES = DATA_W / 8;

  // 256-bit vector registers
  localparam int unsigned VREG_WORDS = 8;
  localparam int unsigned VLEN_BYTES = VREG_WORDS * DATA_BYTES;

  // Index widths derived from the sizes above
  localparam int unsigned BOFF_W = $clog2(DATA_BYTES);
  localparam int unsigned WIDX_W = $clog2(VREG_WORDS);

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [31:0]           addr_t;
  typedef logic [DATA_W-1:0]     word_t;
  typedef logic [DATA_BYTES-1:0] be_t;

  // Counts from 0 up to and including VLEN_BYTES
  typedef logic [$clog2(VLEN_BYTES):0] vl_t;

  typedef logic [4:0] vreg_t;

  // Register number followed by the word inside the register
  typedef logic [$bits(vreg_t)+WIDX_W-1:0] vrf_addr_t;

  typedef logic [2:0]        insn_id_t;
  typedef logic [BOFF_W-1:0] boff_t;

endpackage

// ==== vlsu_isa_pkg.sv ====
// Vector memory instruction encodings

package vlsu_isa_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Memory operations
  ////////////////////////////////////////////////////////////////////////////

  // Bit 0 marks a store, bit 1 marks a strided access
  typedef enum logic [1:0] {
    VLE  = 2'b00,
    VSE  = 2'b01,
    VLSE = 2'b10,
    VSSE = 2'b11
  } vlsu_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Element widths
  ////////////////////////////////////////////////////////////////////////////

  // Element size in bytes is 1 << vsew
  typedef enum logic [1:0] {
    EW_8  = 2'b00,
    EW_16 = 2'b01,
    EW_32 = 2'b10
  } vsew_e;

endpackage

// ==== vlsu_controller.sv ====
// Vector LSU sequencing controller

`timescale 1ns/100ps

module vlsu_controller (
  input  logic                    clk_i,
  input  logic                    rst_i,

  // Instruction request
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  vlsu_isa_pkg::vlsu_op_e  req_op_i,
  input  vlsu_isa_pkg::vsew_e     req_vsew_i,
  input  vlsu_cfg_pkg::vl_t       req_vl_i,
  input  vlsu_cfg_pkg::addr_t     req_rs1_i,
  input  vlsu_cfg_pkg::addr_t     req_rs2_i,
  input  vlsu_cfg_pkg::vreg_t     req_vd_i,
  input  vlsu_cfg_pkg::insn_id_t  req_id_i,

  // Completion response
  output logic                    rsp_valid_o,
  output vlsu_cfg_pkg::insn_id_t  rsp_id_o,
  output vlsu_cfg_pkg::vreg_t     rsp_vd_o,

  // Acknowledges from memory and VRF
  input  logic                    wb_ack_i,
  input  logic                    vrf_wvalid_i,
  input  logic                    vrf_rvalid_i,
  input  vlsu_cfg_pkg::vl_t       beat_bytes_i,

  // Bus control
  output logic                    wb_cyc_o,
  output logic                    wb_stb_o,
  output logic                    wb_we_o,
  output logic                    vrf_we_o,
  output logic                    vrf_re_o,
  output logic                    cap_mem_o,
  output logic                    cap_vrf_o,

  // Registered instruction fields
  output vlsu_isa_pkg::vlsu_op_e  op_o,
  output vlsu_isa_pkg::vsew_e     vsew_o,
  output vlsu_cfg_pkg::addr_t     rs1_o,
  output vlsu_cfg_pkg::addr_t     rs2_o,
  output vlsu_cfg_pkg::vreg_t     vd_o,
  output vlsu_cfg_pkg::vl_t       byte_cnt_o,
  output vlsu_cfg_pkg::vl_t       byte_len_o
);

  import vlsu_cfg_pkg::*;
  import vlsu_isa_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    MEM,
    VRF,
    DONE
  } state_e;

  state_e   state_q;
  state_e   state_d;

  vlsu_op_e op_q;
  vsew_e    vsew_q;
  addr_t    rs1_q;
  addr_t    rs2_q;
  vreg_t    vd_q;
  insn_id_t id_q;

  vl_t      byte_cnt_q;
  vl_t      byte_len_q;
  vl_t      cnt_next;

  // Two spare bits so an oversized vl is still visible
  logic [$bits(vl_t)+1:0] req_len_full;
  vl_t                    req_len;

  logic     accept;
  logic     is_load;
  logic     beat_end;
  logic     last_beat;

  assign req_ready_o = (state_q == IDLE);
  assign accept      = req_valid_i & req_ready_o;

  // Element count to byte count
  assign req_len_full = {2'b00, req_vl_i} << req_vsew_i;
  assign req_len      = req_len_full[$bits(vl_t)-1:0];

  assign is_load = (op_q == VLE) || (op_q == VLSE);

  // The second phase of a beat closes it
  assign beat_end  = (is_load & (state_q == VRF) & vrf_wvalid_i) |
                     (~is_load & (state_q == MEM) & wb_ack_i);
  assign cnt_next  = byte_cnt_q + beat_bytes_i;
  assign last_beat = (cnt_next >= byte_len_q);

  ////////////////////////////////////////////////////////////////////////////
  // Instruction and counter registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q   <= req_op_i;
      vsew_q <= req_vsew_i;
      rs1_q  <= req_rs1_i;
      rs2_q  <= req_rs2_i;
      vd_q   <= req_vd_i;
      id_q   <= req_id_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= IDLE;
      byte_cnt_q <= '0;
      byte_len_q <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        byte_cnt_q <= '0;
        byte_len_q <= req_len;
      end else if (beat_end) begin
        byte_cnt_q <= cnt_next;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Phase sequencing
  ////////////////////////////////////////////////////////////////////////////

  // Loads run MEM then VRF per beat, stores VRF then MEM
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (accept) begin
          if (req_len == '0) begin
            state_d = DONE;
          end else if ((req_op_i == VLE) || (req_op_i == VLSE)) begin
            state_d = MEM;
          end else begin
            state_d = VRF;
          end
        end
      end
      MEM: begin
        if (wb_ack_i) begin
          if (is_load) begin
            state_d = VRF;
          end else begin
            state_d = last_beat ? DONE : VRF;
          end
        end
      end
      VRF: begin
        if (is_load && vrf_wvalid_i) begin
          state_d = last_beat ? DONE : MEM;
        end else if (!is_load && vrf_rvalid_i) begin
          state_d = MEM;
        end
      end
      DONE: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // Bus strobes follow the registered state
  assign wb_cyc_o  = (state_q == MEM);
  assign wb_stb_o  = (state_q == MEM);
  assign wb_we_o   = (state_q == MEM) & ~is_load;
  assign vrf_we_o  = (state_q == VRF) & is_load;
  assign vrf_re_o  = (state_q == VRF) & ~is_load;

  // Staging register loads at the end of the first phase
  assign cap_mem_o = (state_q == MEM) & is_load & wb_ack_i;
  assign cap_vrf_o = (state_q == VRF) & ~is_load & vrf_rvalid_i;

  assign rsp_valid_o = (state_q == DONE);
  assign rsp_id_o    = id_q;
  assign rsp_vd_o    = vd_q;

  assign op_o       = op_q;
  assign vsew_o     = vsew_q;
  assign rs1_o      = rs1_q;
  assign rs2_o      = rs2_q;
  assign vd_o       = vd_q;
  assign byte_cnt_o = byte_cnt_q;
  assign byte_len_o = byte_len_q;

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // An accepted instruction fits in one vector register
  a_len_fits: assert property (@(posedge clk_i) disable iff (rst_i)
    accept |-> (req_len_full <= VLEN_BYTES));

  // Wishbone request and its beat size are held until the slave acknowledges
  a_stb_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (wb_stb_o && !wb_ack_i) |=> (wb_stb_o && $stable(beat_bytes_i)));

endmodule

// ==== vlsu_addr_gen.sv ====
// Vector LSU address generation

`timescale 1ns/100ps

module vlsu_addr_gen (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  vlsu_isa_pkg::vlsu_op_e  op_i,
  input  vlsu_isa_pkg::vsew_e     vsew_i,
  input  vlsu_cfg_pkg::addr_t     rs1_i,
  input  vlsu_cfg_pkg::addr_t     rs2_i,
  input  vlsu_cfg_pkg::vreg_t     vd_i,
  input  vlsu_cfg_pkg::vl_t       byte_cnt_i,
  input  vlsu_cfg_pkg::vl_t       byte_len_i,
  output vlsu_cfg_pkg::addr_t     wb_adr_o,
  output vlsu_cfg_pkg::vrf_addr_t vrf_addr_o,
  output vlsu_cfg_pkg::boff_t     mem_off_o,
  output vlsu_cfg_pkg::boff_t     reg_off_o,
  output vlsu_cfg_pkg::vl_t       beat_bytes_o
);

  import vlsu_cfg_pkg::*;
  import vlsu_isa_pkg::*;

  logic  is_strided;
  vl_t   elem_size;
  vl_t   elem_idx;
  vl_t   remaining;
  addr_t mem_addr;

  assign is_strided = (op_i == VLSE) || (op_i == VSSE);
  assign elem_size  = vl_t'(1) << vsew_i;

  // Byte counter is a whole number of elements on strided ops
  assign elem_idx  = byte_cnt_i >> vsew_i;
  assign remaining = byte_len_i - byte_cnt_i;

  // Byte address of the current beat
  always_comb begin
    if (is_strided) begin
      mem_addr = rs1_i + addr_t'(elem_idx) * rs2_i;
    end else begin
      mem_addr = rs1_i + addr_t'(byte_cnt_i);
    end
  end

  assign wb_adr_o  = mem_addr & ~addr_t'(DATA_BYTES - 1);
  assign mem_off_o = mem_addr[BOFF_W-1:0];

  // Register side follows the byte counter directly
  assign reg_off_o  = byte_cnt_i[BOFF_W-1:0];
  assign vrf_addr_o = {vd_i, byte_cnt_i[BOFF_W +: WIDX_W]};

  // One element per strided beat, else up to a full word
  always_comb begin
    if (is_strided) begin
      beat_bytes_o = elem_size;
    end else if (remaining < vl_t'(DATA_BYTES)) begin
      beat_bytes_o = remaining;
    end else begin
      beat_bytes_o = vl_t'(DATA_BYTES);
    end
  end

  // Strided elements never straddle a word boundary
  a_stride_align: assert property (@(posedge clk_i) disable iff (rst_i)
    (is_strided && (byte_cnt_i < byte_len_i)) |->
      ((mem_addr & (addr_t'(elem_size) - 1)) == '0));

endmodule

// ==== vlsu_data_align.sv ====
// Vector LSU data alignment

`timescale 1ns/100ps

module vlsu_data_align (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    cap_mem_i,
  input  logic                    cap_vrf_i,
  input  vlsu_cfg_pkg::word_t     wb_dat_i,
  input  vlsu_cfg_pkg::word_t     vrf_rdata_i,
  input  vlsu_isa_pkg::vlsu_op_e  op_i,
  input  vlsu_isa_pkg::vsew_e     vsew_i,
  input  vlsu_cfg_pkg::boff_t     mem_off_i,
  input  vlsu_cfg_pkg::boff_t     reg_off_i,
  input  vlsu_cfg_pkg::vl_t       beat_bytes_i,
  output vlsu_cfg_pkg::word_t     vrf_wdata_o,
  output vlsu_cfg_pkg::be_t       vrf_wbe_o,
  output vlsu_cfg_pkg::word_t     wb_dat_o,
  output vlsu_cfg_pkg::be_t       wb_sel_o
);

  import vlsu_cfg_pkg::*;
  import vlsu_isa_pkg::*;

  // Rotate a word left by whole bytes
  function automatic word_t rotl_bytes(word_t data, boff_t nbytes);
    logic [2*DATA_W-1:0] dbl;
    dbl = {data, data} << {nbytes, 3'b000};
    return dbl[2*DATA_W-1 -: DATA_W];
  endfunction

  word_t stage_q;
  logic  is_strided;
  boff_t load_rot;
  boff_t store_rot;
  be_t   elem_mask;
  be_t   beat_mask;

  ////////////////////////////////////////////////////////////////////////////
  // Staging word
  ////////////////////////////////////////////////////////////////////////////

  // One access in flight, so one word of buffering is enough
  always_ff @(posedge clk_i) begin
    if (cap_mem_i) begin
      stage_q <= wb_dat_i;
    end else if (cap_vrf_i) begin
      stage_q <= vrf_rdata_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Byte rotation and enables
  ////////////////////////////////////////////////////////////////////////////

  assign is_strided = (op_i == VLSE) || (op_i == VSSE);

  // Load moves memory offset to register offset, store goes back
  assign load_rot  = reg_off_i - mem_off_i;
  assign store_rot = mem_off_i - reg_off_i;

  assign vrf_wdata_o = rotl_bytes(stage_q, load_rot);
  assign wb_dat_o    = rotl_bytes(stage_q, store_rot);

  always_comb begin
    unique case (vsew_i)
      EW_8:    elem_mask = be_t'(1);
      EW_16:   elem_mask = be_t'(3);
      default: elem_mask = '1;
    endcase
  end

  // Low beat_bytes lanes for unit stride
  always_comb begin
    for (int k = 0; k < DATA_BYTES; k++) begin
      beat_mask[k] = (vl_t'(k) < beat_bytes_i);
    end
  end

  assign vrf_wbe_o = is_strided ? (elem_mask << reg_off_i) : beat_mask;
  assign wb_sel_o  = is_strided ? (elem_mask << mem_off_i) : beat_mask;

  // The phase after a capture always writes at least one byte
  a_wbe_used: assert property (@(posedge clk_i) disable iff (rst_i)
    cap_mem_i |=> (vrf_wbe_o != '0));

  a_sel_used: assert property (@(posedge clk_i) disable iff (rst_i)
    cap_vrf_i |=> (wb_sel_o != '0));

endmodule

// ==== vlsu_top.sv ====
// Vector load/store unit top level

`timescale 1ns/100ps

module vlsu_top (
  input  logic                    clk_i,
  input  logic                    rst_i,

  // Instruction request
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  vlsu_isa_pkg::vlsu_op_e  req_op_i,
  input  vlsu_isa_pkg::vsew_e     req_vsew_i,
  input  vlsu_cfg_pkg::vl_t       req_vl_i,
  input  vlsu_cfg_pkg::addr_t     req_rs1_i,
  input  vlsu_cfg_pkg::addr_t     req_rs2_i,
  input  vlsu_cfg_pkg::vreg_t     req_vd_i,
  input  vlsu_cfg_pkg::insn_id_t  req_id_i,

  // Completion response
  output logic                    rsp_valid_o,
  output vlsu_cfg_pkg::insn_id_t  rsp_id_o,
  output vlsu_cfg_pkg::vreg_t     rsp_vd_o,

  // Wishbone classic master
  output logic                    wb_cyc_o,
  output logic                    wb_stb_o,
  output logic                    wb_we_o,
  output vlsu_cfg_pkg::addr_t     wb_adr_o,
  output vlsu_cfg_pkg::word_t     wb_dat_o,
  output vlsu_cfg_pkg::be_t       wb_sel_o,
  input  vlsu_cfg_pkg::word_t     wb_dat_i,
  input  logic                    wb_ack_i,

  // VRF port
  output vlsu_cfg_pkg::vrf_addr_t vrf_waddr_o,
  output vlsu_cfg_pkg::word_t     vrf_wdata_o,
  output logic                    vrf_we_o,
  output vlsu_cfg_pkg::be_t       vrf_wbe_o,
  input  logic                    vrf_wvalid_i,
  output vlsu_cfg_pkg::vrf_addr_t vrf_raddr_o,
  output logic                    vrf_re_o,
  input  vlsu_cfg_pkg::word_t     vrf_rdata_i,
  input  logic                    vrf_rvalid_i
);

  import vlsu_cfg_pkg::*;
  import vlsu_isa_pkg::*;

  vlsu_op_e  op;
  vsew_e     vsew;
  addr_t     rs1;
  addr_t     rs2;
  vreg_t     vd;
  vl_t       byte_cnt;
  vl_t       byte_len;
  vl_t       beat_bytes;
  boff_t     mem_off;
  boff_t     reg_off;
  vrf_addr_t vrf_addr;
  logic      cap_mem;
  logic      cap_vrf;

  // Reads and writes never overlap, so both sides share one address
  assign vrf_waddr_o = vrf_addr;
  assign vrf_raddr_o = vrf_addr;

  vlsu_controller u_ctrl (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_op_i     (req_op_i),
    .req_vsew_i   (req_vsew_i),
    .req_vl_i     (req_vl_i),
    .req_rs1_i    (req_rs1_i),
    .req_rs2_i    (req_rs2_i),
    .req_vd_i     (req_vd_i),
    .req_id_i     (req_id_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_id_o     (rsp_id_o),
    .rsp_vd_o     (rsp_vd_o),
    .wb_ack_i     (wb_ack_i),
    .vrf_wvalid_i (vrf_wvalid_i),
    .vrf_rvalid_i (vrf_rvalid_i),
    .beat_bytes_i (beat_bytes),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_we_o      (wb_we_o),
    .vrf_we_o     (vrf_we_o),
    .vrf_re_o     (vrf_re_o),
    .cap_mem_o    (cap_mem),
    .cap_vrf_o    (cap_vrf),
    .op_o         (op),
    .vsew_o       (vsew),
    .rs1_o        (rs1),
    .rs2_o        (rs2),
    .vd_o         (vd),
    .byte_cnt_o   (byte_cnt),
    .byte_len_o   (byte_len)
  );

  vlsu_addr_gen u_addr_gen (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .op_i         (op),
    .vsew_i       (vsew),
    .rs1_i        (rs1),
    .rs2_i        (rs2),
    .vd_i         (vd),
    .byte_cnt_i   (byte_cnt),
    .byte_len_i   (byte_len),
    .wb_adr_o     (wb_adr_o),
    .vrf_addr_o   (vrf_addr),
    .mem_off_o    (mem_off),
    .reg_off_o    (reg_off),
    .beat_bytes_o (beat_bytes)
  );

  vlsu_data_align u_data_align (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cap_mem_i    (cap_mem),
    .cap_vrf_i    (cap_vrf),
    .wb_dat_i     (wb_dat_i),
    .vrf_rdata_i  (vrf_rdata_i),
    .op_i         (op),
    .vsew_i       (vsew),
    .mem_off_i    (mem_off),
    .reg_off_i    (reg_off),
    .beat_bytes_i (beat_bytes),
    .vrf_wdata_o  (vrf_wdata_o),
    .vrf_wbe_o    (vrf_wbe_o),
    .wb_dat_o     (wb_dat_o),
    .wb_sel_o     (wb_sel_o)
  );

endmodule

// ==== tb_vlsu_ref.svh ====
// Testbench reference model

`ifndef TB_VLSU_REF_SVH
`define TB_VLSU_REF_SVH

// One xorshift step on a 32-bit state
function automatic logic [31:0] xorshift32(logic [31:0] x);
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// Next value from the shared generator, reduced to 0 .. n-1
function automatic int unsigned rand_below(int unsigned n);
  rng_state = xorshift32(rng_state);
  return rng_state % n;
endfunction

// Byte-level effect of one instruction on the reference copies
function automatic void apply_reference(vlsu_op_e op, vsew_e vsew, int unsigned vl,
                                        addr_t base, addr_t stride, vreg_t vd);
  int unsigned esz;
  int unsigned nbytes;
  int unsigned rbyte;
  addr_t       maddr;
  logic        is_store;
  logic        is_strided;
  esz        = 1 << vsew;
  nbytes     = vl * esz;
  is_store   = (op == VSE) || (op == VSSE);
  is_strided = (op == VLSE) || (op == VSSE);
  for (int unsigned i = 0; i < nbytes; i++) begin
    // Element i / esz sits at base + index * stride in memory
    if (is_strided) begin
      maddr = base + (i / esz) * stride + (i % esz);
    end else begin
      maddr = base + i;
    end
    // Register bytes are packed from the start of vd
    rbyte = vd * VLEN_BYTES + i;
    if (is_store) begin
      ref_mem[maddr[11:2]][8*maddr[1:0] +: 8] = ref_vrf[rbyte / 4][8*(rbyte % 4) +: 8];
    end else begin
      ref_vrf[rbyte / 4][8*(rbyte % 4) +: 8] = ref_mem[maddr[11:2]][8*maddr[1:0] +: 8];
    end
  end
endfunction

`endif

// ==== tb_vlsu_top.sv ====
// Vector LSU testbench

`timescale 1ns/100ps

module tb_vlsu_top;

  import vlsu_cfg_pkg::*;
  import vlsu_isa_pkg::*;

  localparam time         CLK_HALF   = 50ns;
  localparam time         DRV_DLY    = 10ns;
  localparam int unsigned RST_CYCLES = 8;
  localparam int unsigned N_DIRECTED = 12;
  localparam int unsigned N_RANDOM   = 40;
  // Every instruction at most 32 beats of about 12 cycles
  localparam int unsigned MAX_CYCLES = (N_DIRECTED + N_RANDOM) * VLEN_BYTES * 12;

  logic      clk_i;
  logic      rst_i;
  logic      req_valid_i;
  logic      req_ready_o;
  vlsu_op_e  req_op_i;
  vsew_e     req_vsew_i;
  vl_t       req_vl_i;
  addr_t     req_rs1_i;
  addr_t     req_rs2_i;
  vreg_t     req_vd_i;
  insn_id_t  req_id_i;
  logic      rsp_valid_o;
  insn_id_t  rsp_id_o;
  vreg_t     rsp_vd_o;
  logic      wb_cyc_o;
  logic      wb_stb_o;
  logic      wb_we_o;
  addr_t     wb_adr_o;
  word_t     wb_dat_o;
  be_t       wb_sel_o;
  word_t     wb_dat_i;
  logic      wb_ack_i;
  vrf_addr_t vrf_waddr_o;
  word_t     vrf_wdata_o;
  logic      vrf_we_o;
  be_t       vrf_wbe_o;
  logic      vrf_wvalid_i;
  vrf_addr_t vrf_raddr_o;
  logic      vrf_re_o;
  word_t     vrf_rdata_i;
  logic      vrf_rvalid_i;

  // Models and their reference copies
  word_t       mem [1024];
  word_t       vrf [256];
  word_t       ref_mem [1024];
  word_t       ref_vrf [256];
  logic [31:0] rng_state;

  int unsigned cycle_cnt;
  int unsigned test_cnt;
  int unsigned fail_cnt;
  int unsigned err_cnt;
  int unsigned issued_cnt;
  int unsigned checked_cnt;
  int unsigned stb_cnt;
  int unsigned we_cnt;
  int unsigned re_cnt;
  int unsigned mem_wait;
  int unsigned vrf_wait;
  logic        mem_busy;
  logic        vrf_busy;
  string       exp_name;
  insn_id_t    exp_id;
  vreg_t       exp_vd;
  insn_id_t    next_id;

  `include "tb_vlsu_ref.svh"

  vlsu_top UUT (.*);

  always #(CLK_HALF) clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    err_cnt++;
    $display("** Error %s: %s expected 0x%h actual 0x%h", name, what, exp, act);
  endtask

  task automatic close_test(input string name, input int unsigned err_before);
    test_cnt++;
    if (err_cnt != err_before) begin
      fail_cnt++;
      $display("FAIL %s", name);
    end else begin
      $display("ok   %s", name);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////////
  // Memory and VRF models
  //////////////////////////////////////////////////////////////////////////////

  // Wishbone slave, ack after 0 to 3 wait cycles
  always @(posedge clk_i) begin
    #(DRV_DLY);
    if (wb_ack_i) begin
      wb_ack_i = 1'b0;
    end else if (wb_cyc_o && wb_stb_o) begin
      if (!mem_busy) begin
        mem_busy = 1'b1;
        mem_wait = rand_below(4);
      end
      if (mem_wait == 0) begin
        if (wb_we_o) begin
          for (int k = 0; k < DATA_BYTES; k++) begin
            if (wb_sel_o[k]) mem[wb_adr_o[11:2]][8*k +: 8] = wb_dat_o[8*k +: 8];
          end
        end else begin
          wb_dat_i = mem[wb_adr_o[11:2]];
        end
        wb_ack_i = 1'b1;
        mem_busy = 1'b0;
      end else begin
        mem_wait--;
      end
    end
  end

  always @(posedge clk_i) begin
    #(DRV_DLY);
    if (vrf_wvalid_i || vrf_rvalid_i) begin
      vrf_wvalid_i = 1'b0;
      vrf_rvalid_i = 1'b0;
    end else if (vrf_we_o || vrf_re_o) begin
      if (!vrf_busy) begin
        vrf_busy = 1'b1;
        vrf_wait = rand_below(4);
      end
      if (vrf_wait == 0) begin
        if (vrf_we_o) begin
          for (int k = 0; k < DATA_BYTES; k++) begin
            if (vrf_wbe_o[k]) vrf[vrf_waddr_o][8*k +: 8] = vrf_wdata_o[8*k +: 8];
          end
          vrf_wvalid_i = 1'b1;
        end else begin
          vrf_rdata_i  = vrf[vrf_raddr_o];
          vrf_rvalid_i = 1'b1;
        end
        vrf_busy = 1'b0;
      end else begin
        vrf_wait--;
      end
    end
  end

  // Access cycles, used by the zero-length test
  always @(posedge clk_i) begin
    #(DRV_DLY);
    if (wb_stb_o) stb_cnt++;
    if (vrf_we_o) we_cnt++;
    if (vrf_re_o) re_cnt++;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: no completion within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // Response compare
  //////////////////////////////////////////////////////////////////////////////

  task automatic compare_models();
    int unsigned err_before;
    logic        bad;
    err_before = err_cnt;
    if (checked_cnt == issued_cnt) begin
      err_cnt++;
      $display("Response arrived with no instruction outstanding");
    end else begin
      if (rsp_id_o !== exp_id) report_mismatch(exp_name, "rsp_id_o", exp_id, rsp_id_o);
      if (rsp_vd_o !== exp_vd) report_mismatch(exp_name, "rsp_vd_o", exp_vd, rsp_vd_o);
      // First differing word of each array
      bad = 1'b0;
      for (int i = 0; i < 1024; i++) begin
        if (!bad && mem[i] !== ref_mem[i]) begin
          report_mismatch(exp_name, $sformatf("mem[%0d]", i), ref_mem[i], mem[i]);
          bad = 1'b1;
        end
      end
      bad = 1'b0;
      for (int i = 0; i < 256; i++) begin
        if (!bad && vrf[i] !== ref_vrf[i]) begin
          report_mismatch(exp_name, $sformatf("vrf[%0d]", i), ref_vrf[i], vrf[i]);
          bad = 1'b1;
        end
      end
      // Next instruction starts from the current model contents
      ref_mem = mem;
      ref_vrf = vrf;
      close_test(exp_name, err_before);
      checked_cnt++;
    end
  endtask

  always @(posedge clk_i) begin
    #(DRV_DLY);
    if (!rst_i && rsp_valid_o) compare_models();
  end

  //////////////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////////////

  task automatic run_insn(input string name, input vlsu_op_e op, input vsew_e vsew,
                          input int unsigned vl, input addr_t base, input addr_t stride,
                          input vreg_t vd);
    apply_reference(op, vsew, vl, base, stride, vd);
    exp_name = name;
    exp_id   = next_id;
    exp_vd   = vd;
    issued_cnt++;
    while (!req_ready_o) begin
      @(posedge clk_i);
      #(DRV_DLY);
    end
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_vsew_i  = vsew;
    req_vl_i    = vl_t'(vl);
    req_rs1_i   = base;
    req_rs2_i   = stride;
    req_vd_i    = vd;
    req_id_i    = next_id;
    @(posedge clk_i);
    #(DRV_DLY);
    req_valid_i = 1'b0;
    next_id++;
    wait (checked_cnt == issued_cnt);
  endtask

  initial begin
    int unsigned err_before;
    int unsigned stb_before;
    int unsigned we_before;
    int unsigned re_before;
    vlsu_op_e    op;
    vsew_e       vsew;
    int unsigned esz;
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    req_valid_i  = 1'b0;
    req_op_i     = VLE;
    req_vsew_i   = EW_8;
    req_vl_i     = '0;
    req_rs1_i    = '0;
    req_rs2_i    = '0;
    req_vd_i     = '0;
    req_id_i     = '0;
    wb_dat_i     = '0;
    wb_ack_i     = 1'b0;
    vrf_wvalid_i = 1'b0;
    vrf_rdata_i  = '0;
    vrf_rvalid_i = 1'b0;
    rng_state    = 32'd9348;
    {cycle_cnt, test_cnt, fail_cnt, err_cnt} = '0;
    {issued_cnt, checked_cnt, stb_cnt, we_cnt, re_cnt} = '0;
    {mem_wait, vrf_wait, mem_busy, vrf_busy} = '0;
    next_id = '0;
    for (int i = 0; i < 1024; i++) mem[i] = (i * 32'h9E3779B1) ^ 32'h5A5A0000;
    for (int i = 0; i < 256; i++) vrf[i] = (i * 32'h85EBCA6B) ^ 32'hC3C30000;
    ref_mem = mem;
    ref_vrf = vrf;

    repeat (RST_CYCLES) @(posedge clk_i);
    #(DRV_DLY);
    rst_i = 1'b0;

    err_before = err_cnt;
    if (req_ready_o !== 1'b1) report_mismatch("reset", "req_ready_o", 1, req_ready_o);
    if ({wb_cyc_o, wb_stb_o, wb_we_o, vrf_we_o, vrf_re_o, rsp_valid_o} !== 6'b0) begin
      report_mismatch("reset", "control outputs", 0,
                      {wb_cyc_o, wb_stb_o, wb_we_o, vrf_we_o, vrf_re_o, rsp_valid_o});
    end
    close_test("reset", err_before);

    // Unit stride with a partial last word
    run_insn("vle_e8_vl7", VLE, EW_8, 7, 32'h100, 0, 5'd1);
    run_insn("vle_e16_vl5", VLE, EW_16, 5, 32'h180, 0, 5'd2);
    run_insn("vle_e32_vl6", VLE, EW_32, 6, 32'h200, 0, 5'd3);
    run_insn("vse_e8_vl13", VSE, EW_8, 13, 32'h400, 0, 5'd4);
    run_insn("vse_e16_vl3", VSE, EW_16, 3, 32'h480, 0, 5'd5);
    run_insn("vse_e32_vl8", VSE, EW_32, 8, 32'h500, 0, 5'd6);

    // Strides off the word grid
    run_insn("vlse_e8_s3", VLSE, EW_8, 9, 32'h600, 3, 5'd7);
    run_insn("vlse_e16_s6", VLSE, EW_16, 5, 32'h680, 6, 5'd8);
    run_insn("vsse_e8_s5", VSSE, EW_8, 11, 32'h700, 5, 5'd9);
    run_insn("vsse_e16_s10", VSSE, EW_16, 6, 32'h780, 10, 5'd10);

    stb_before = stb_cnt;
    we_before  = we_cnt;
    re_before  = re_cnt;
    run_insn("zero_vl", VLE, EW_16, 0, 32'h800, 0, 5'd11);
    err_before = err_cnt;
    if (stb_cnt != stb_before) report_mismatch("zero_vl_access", "stb", 0, stb_cnt - stb_before);
    if (we_cnt != we_before) report_mismatch("zero_vl_access", "vrf_we", 0, we_cnt - we_before);
    if (re_cnt != re_before) report_mismatch("zero_vl_access", "vrf_re", 0, re_cnt - re_before);
    close_test("zero_vl_access", err_before);

    // Random mix, stride a multiple of the element size
    for (int n = 0; n < N_RANDOM; n++) begin
      op   = vlsu_op_e'(rand_below(4));
      vsew = vsew_e'(rand_below(3));
      esz  = 1 << vsew;
      run_insn($sformatf("rand_%0d", n), op, vsew, rand_below(VLEN_BYTES / esz + 1),
               rand_below(512) * 4, (rand_below(12) + 1) * esz, vreg_t'(rand_below(32)));
    end

    $display("Tests run %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== vlsu_top.f ====
+incdir+.
vlsu_cfg_pkg.sv
vlsu_isa_pkg.sv
vlsu_controller.sv
vlsu_addr_gen.sv
vlsu_data_align.sv
vlsu_top.sv
tb_vlsu_top.sv

// ==== Bender.yml ====
package:
  name: vlsu

sources:
  - vlsu_cfg_pkg.sv
  - vlsu_isa_pkg.sv
  - vlsu_controller.sv
  - vlsu_addr_gen.sv
  - vlsu_data_align.sv
  - vlsu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_vlsu_top.sv
